// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int ADDR_W  = 8;
	localparam int DATA_W  = 16;
	localparam int ENTRIES = 8;
	localparam int IDX_W   = $clog2(ENTRIES);
	localparam int AGE_W   = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IDX_W-1:0]  idx_t;
	typedef logic [AGE_W-1:0]  age_t;

	localparam age_t AGE_MAX = '1; // a freshly touched entry is the most recently used

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_e;

	// request sequencing in the miss controller
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_SEARCH,
		ST_EVICT,
		ST_FETCH,
		ST_RESP
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: common/entry_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// link between the miss controller and the entry array
interface entry_bus;

	logic               fill;      // one-cycle write strobe
	cache_pkg::idx_t    fill_idx;
	cache_pkg::addr_t   fill_tag;
	cache_pkg::data_t   fill_data;
	cache_pkg::addr_t   look_tag;  // lookup results follow this combinationally
	logic               hit;
	cache_pkg::idx_t    hit_idx;
	logic               has_empty;
	cache_pkg::idx_t    empty_idx;
	cache_pkg::idx_t    rd_idx;
	cache_pkg::addr_t   rd_tag;
	cache_pkg::data_t   rd_data;
	logic               rd_valid;

	modport ctrl (
		output fill, fill_idx, fill_tag, fill_data, look_tag, rd_idx,
		input  hit, hit_idx, has_empty, empty_idx, rd_tag, rd_data, rd_valid
	);

	modport store (
		input  fill, fill_idx, fill_tag, fill_data, look_tag, rd_idx,
		output hit, hit_idx, has_empty, empty_idx, rd_tag, rd_data, rd_valid
	);

endinterface

`default_nettype wire

// File: cache_store/entry_array.sv
`timescale 1ns/1ns
`default_nettype none

module entry_array (
	input logic      clk,
	input logic      rst_n,
	entry_bus.store  bus
);

	logic [cache_pkg::ENTRIES-1:0] valid;
	cache_pkg::addr_t              tags  [cache_pkg::ENTRIES];
	cache_pkg::data_t              words [cache_pkg::ENTRIES];
	logic [cache_pkg::ENTRIES-1:0] match;
	cache_pkg::idx_t               hit_idx;
	cache_pkg::idx_t               empty_idx;

	// valid bits mark which tags and words are in use
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (bus.fill) begin
			valid[bus.fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.fill) begin
			tags[bus.fill_idx]  <= bus.fill_tag;
			words[bus.fill_idx] <= bus.fill_data;
		end
	end

	// every entry compares its own tag in parallel
	always_comb begin
		for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
			match[i] = valid[i] && (tags[i] == bus.look_tag);
		end
	end

	// walking downwards leaves the lowest index as the winner
	always_comb begin
		hit_idx   = '0;
		empty_idx = '0;
		for (int i = cache_pkg::ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) hit_idx = cache_pkg::idx_t'(i);
			if (!valid[i]) empty_idx = cache_pkg::idx_t'(i); // lowest free slot gets the next fill
		end
	end

	assign bus.hit       = |match;
	assign bus.hit_idx   = hit_idx;
	assign bus.has_empty = ~&valid;
	assign bus.empty_idx = empty_idx;

	assign bus.rd_tag   = tags[bus.rd_idx];
	assign bus.rd_data  = words[bus.rd_idx];
	assign bus.rd_valid = valid[bus.rd_idx];

	// the controller must never allocate a second entry for a tag already present
	a_single_match: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match))
		else $error("ERR match=%h look_tag=%h", match, bus.look_tag);

endmodule

`default_nettype wire

// File: cache_store/age_timers.sv
`timescale 1ns/1ns
`default_nettype none

module age_timers (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        tick,
	input  logic                                        touch,
	input  cache_pkg::idx_t                             touch_idx,
	input  logic                                        fill,
	input  cache_pkg::idx_t                             fill_idx,
	output cache_pkg::age_t [cache_pkg::ENTRIES-1:0]    ages,
	output logic [cache_pkg::ENTRIES-1:0]               valid
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ages  <= '0;
			valid <= '0;
		end else begin
			for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
				if (touch && touch_idx == cache_pkg::idx_t'(i)) begin
					ages[i] <= cache_pkg::AGE_MAX; // touch wins over the tick for its own entry
				end else if (tick && valid[i] && ages[i] != '0) begin
					ages[i] <= ages[i] - cache_pkg::age_t'(1); // saturates at zero
				end
			end
			if (fill) valid[fill_idx] <= 1'b1; // invalid entries never age
		end
	end

endmodule

`default_nettype wire

// File: hdl/victim_scan.sv
`timescale 1ns/1ns
`default_nettype none

module victim_scan (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     start,
	input  cache_pkg::age_t [cache_pkg::ENTRIES-1:0] ages,
	input  logic [cache_pkg::ENTRIES-1:0]            valid,
	output logic                                     done,
	output cache_pkg::idx_t                          victim_idx
);

	logic            busy;
	logic            found; // something has been kept since start
	cache_pkg::idx_t scan_idx;
	cache_pkg::age_t best_age;
	cache_pkg::age_t cur_age;
	logic            take;
	logic            last;

	assign cur_age = ages[scan_idx];

	// strictly smaller only, so ties stay with the lower index
	assign take = valid[scan_idx] && (!found || cur_age < best_age);

	// an age of zero cannot be beaten, no need to look further
	assign last = (take && cur_age == '0) ||
		(scan_idx == cache_pkg::idx_t'(cache_pkg::ENTRIES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			found <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				found <= 1'b0;
			end else if (busy) begin
				if (take) found <= 1'b1;
				if (last) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			scan_idx <= '0;
		end else if (busy) begin
			scan_idx <= scan_idx + cache_pkg::idx_t'(1); // one entry per cycle
			if (take) begin
				best_age   <= cur_age;
				victim_idx <= scan_idx;
			end
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("ERR done=%h victim_idx=%h", done, victim_idx);

endmodule

`default_nettype wire

// File: hdl/miss_control.sv
`timescale 1ns/1ns
`default_nettype none

module miss_control (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  cache_pkg::op_e     req_op,
	input  cache_pkg::addr_t   req_addr,
	input  cache_pkg::data_t   req_wdata,
	input  logic               scan_done,
	input  cache_pkg::idx_t    victim_idx,
	input  logic               evict_ack,
	input  logic               fetch_valid,
	input  cache_pkg::data_t   fetch_data,
	output logic               ready,
	output logic               resp_valid,
	output cache_pkg::data_t   resp_rdata,
	output logic               scan_start,
	output logic               tick,
	output logic               touch,
	output cache_pkg::idx_t    touch_idx,
	output logic               evict_valid,
	output cache_pkg::addr_t   evict_addr,
	output cache_pkg::data_t   evict_data,
	output logic               fetch_req,
	output cache_pkg::addr_t   fetch_addr,
	entry_bus.ctrl             bus
);

	cache_pkg::ctrl_state_e state, state_d;
	cache_pkg::op_e         op_q;
	cache_pkg::addr_t       addr_q;
	cache_pkg::data_t       wdata_q;
	cache_pkg::idx_t        idx_q;       // entry the current request works on
	cache_pkg::idx_t        target_idx;
	cache_pkg::data_t       fill_data;
	logic                   alloc;       // the target entry is free for the new tag
	logic                   fill;

	assign ready      = (state == cache_pkg::ST_IDLE);
	assign resp_valid = (state == cache_pkg::ST_RESP);
	assign tick       = ready && req_valid; // ages step once per accepted request

	always_comb begin
		case (state)
			cache_pkg::ST_LOOKUP: target_idx = bus.hit ? bus.hit_idx : bus.empty_idx;
			cache_pkg::ST_SEARCH: target_idx = victim_idx;
			default:              target_idx = idx_q;
		endcase
	end

	assign fill_data = (state == cache_pkg::ST_FETCH) ? fetch_data : wdata_q;

	always_comb begin
		state_d    = state;
		alloc      = 1'b0;
		fill       = 1'b0;
		scan_start = 1'b0;
		case (state)
			cache_pkg::ST_IDLE: if (req_valid) state_d = cache_pkg::ST_LOOKUP;
			cache_pkg::ST_LOOKUP: begin
				if (bus.hit) begin
					fill    = (op_q == cache_pkg::OP_WRITE); // write hit refreshes the word
					state_d = cache_pkg::ST_RESP;
				end else if (bus.has_empty) begin
					alloc = 1'b1;
				end else begin
					scan_start = 1'b1;
					state_d    = cache_pkg::ST_SEARCH;
				end
			end
			cache_pkg::ST_SEARCH: begin
				if (scan_done) begin
					if (bus.rd_valid) state_d = cache_pkg::ST_EVICT;
					else alloc = 1'b1;
				end
			end
			cache_pkg::ST_EVICT: if (evict_ack) alloc = 1'b1;
			cache_pkg::ST_FETCH: begin
				if (fetch_valid) begin
					fill    = 1'b1;
					state_d = cache_pkg::ST_RESP;
				end
			end
			cache_pkg::ST_RESP: state_d = cache_pkg::ST_IDLE;
			default: state_d = cache_pkg::ST_IDLE;
		endcase
		// a write needs no fetch, the word arrives with the request
		if (alloc) begin
			if (op_q == cache_pkg::OP_WRITE) begin
				fill    = 1'b1;
				state_d = cache_pkg::ST_RESP;
			end else begin
				state_d = cache_pkg::ST_FETCH;
			end
		end
	end

	assign touch     = fill || (state == cache_pkg::ST_LOOKUP && bus.hit);
	assign touch_idx = target_idx;

	assign bus.fill      = fill;
	assign bus.fill_idx  = target_idx;
	assign bus.fill_tag  = addr_q;
	assign bus.fill_data = fill_data;
	assign bus.look_tag  = addr_q;
	assign bus.rd_idx    = target_idx;

	// the victim entry is left alone until the ack, so the indexed read stays stable
	assign evict_valid = (state == cache_pkg::ST_EVICT);
	assign evict_addr  = bus.rd_tag;
	assign evict_data  = bus.rd_data;
	assign fetch_addr  = addr_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= cache_pkg::ST_IDLE;
			fetch_req <= 1'b0;
		end else begin
			state     <= state_d;
			fetch_req <= alloc && (op_q == cache_pkg::OP_READ); // first cycle of ST_FETCH
		end
	end

	always_ff @(posedge clk) begin
		if (tick) begin
			op_q    <= req_op;
			addr_q  <= req_addr;
			wdata_q <= req_wdata;
		end
		idx_q <= target_idx;
		if (fill) resp_rdata <= fill_data;
		else if (state == cache_pkg::ST_LOOKUP && bus.hit) resp_rdata <= bus.rd_data;
	end

	a_evict_fetch_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(fetch_req && evict_valid))
		else $error("ERR fetch_req=%h evict_valid=%h", fetch_req, evict_valid);

	a_evict_hold: assert property (@(posedge clk) disable iff (!rst_n)
		evict_valid && !evict_ack |=> evict_valid && $stable(evict_addr))
		else $error("ERR evict_addr=%h evict_valid=%h", evict_addr, evict_valid);

endmodule

`default_nettype wire

// File: hdl/assoc_cache.sv
`timescale 1ns/1ns
`default_nettype none

module assoc_cache (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  cache_pkg::op_e     req_op,
	input  cache_pkg::addr_t   req_addr,
	input  cache_pkg::data_t   req_wdata,
	input  logic               evict_ack,
	input  logic               fetch_valid,
	input  cache_pkg::data_t   fetch_data,
	output logic               ready,
	output logic               resp_valid,
	output cache_pkg::data_t   resp_rdata,
	output logic               evict_valid,
	output cache_pkg::addr_t   evict_addr,
	output cache_pkg::data_t   evict_data,
	output logic               fetch_req,
	output cache_pkg::addr_t   fetch_addr
);

	logic                                     tick;
	logic                                     touch;
	cache_pkg::idx_t                          touch_idx;
	cache_pkg::age_t [cache_pkg::ENTRIES-1:0] ages;
	logic [cache_pkg::ENTRIES-1:0]            age_valid;
	logic                                     scan_start;
	logic                                     scan_done;
	cache_pkg::idx_t                          victim_idx;

	entry_bus ebus ();

	// lookup stage
	entry_array u_entry_array (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (ebus.store)
	);

	age_timers u_age_timers (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.touch     (touch),
		.touch_idx (touch_idx),
		.fill      (ebus.fill),
		.fill_idx  (ebus.fill_idx),
		.ages      (ages),
		.valid     (age_valid)
	);

	// victim search, only started when every entry is taken
	victim_scan u_victim_scan (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (scan_start),
		.ages       (ages),
		.valid      (age_valid),
		.done       (scan_done),
		.victim_idx (victim_idx)
	);

	miss_control u_miss_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.scan_done   (scan_done),
		.victim_idx  (victim_idx),
		.evict_ack   (evict_ack),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data),
		.ready       (ready),
		.resp_valid  (resp_valid),
		.resp_rdata  (resp_rdata),
		.scan_start  (scan_start),
		.tick        (tick),
		.touch       (touch),
		.touch_idx   (touch_idx),
		.evict_valid (evict_valid),
		.evict_addr  (evict_addr),
		.evict_data  (evict_data),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.bus         (ebus.ctrl)
	);

endmodule

`default_nettype wire

// File: dv/backing_mem.sv
`timescale 1ns/1ns
`default_nettype none

// the backing store serves one transfer at a time after a random delay
module backing_mem #(
	parameter cache_pkg::data_t FILL_KEY = 16'h0000
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             fetch_req,
	input  cache_pkg::addr_t fetch_addr,
	output logic             fetch_valid,
	output cache_pkg::data_t fetch_data,
	input  logic             evict_valid,
	input  cache_pkg::addr_t evict_addr,
	input  cache_pkg::data_t evict_data,
	output logic             evict_ack
);

	cache_pkg::data_t mem [2**cache_pkg::ADDR_W];
	cache_pkg::addr_t fetch_addr_q;
	logic             serving_fetch;
	int               wait_left;      // cycles until the pending answer goes out

	initial begin
		for (int a = 0; a < 2**cache_pkg::ADDR_W; a++) begin
			mem[a] = cache_pkg::data_t'(a) ^ FILL_KEY;
		end
		fetch_valid   = 1'b0;
		fetch_data    = '0;
		evict_ack     = 1'b0;
		fetch_addr_q  = '0;
		serving_fetch = 1'b0;
		wait_left     = 0;
		forever begin
			@(posedge clk);
			#2;
			fetch_valid = 1'b0; // both answers are one-cycle pulses
			evict_ack   = 1'b0;
			if (!rst_n) begin
				wait_left = 0;
			end else if (wait_left > 0) begin
				wait_left--;
				if (wait_left == 0 && serving_fetch) begin
					fetch_data  = mem[fetch_addr_q];
					fetch_valid = 1'b1;
				end else if (wait_left == 0) begin
					mem[evict_addr] = evict_data; // written-back word replaces the old one
					evict_ack       = 1'b1;
				end
			end else if (fetch_req) begin
				fetch_addr_q  = fetch_addr;
				serving_fetch = 1'b1;
				wait_left     = 1 + int'($urandom % 5);
			end else if (evict_valid) begin
				serving_fetch = 1'b0;
				wait_left     = 1 + int'($urandom % 5);
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_assoc_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_assoc_cache;

	localparam int               WAIT_LIMIT = 200;
	localparam cache_pkg::data_t FILL_KEY   = 16'hc35a;

	logic clk, rst_n, req_valid, ready, resp_valid, accept;
	logic evict_valid, evict_ack, fetch_req, fetch_valid;
	cache_pkg::op_e   req_op;
	cache_pkg::addr_t req_addr, evict_addr, fetch_addr;
	cache_pkg::data_t req_wdata, resp_rdata, evict_data, fetch_data;

	// reference model of the cache contents and the backing store
	logic             m_valid [cache_pkg::ENTRIES];
	cache_pkg::addr_t m_tag   [cache_pkg::ENTRIES];
	cache_pkg::data_t m_data  [cache_pkg::ENTRIES];
	cache_pkg::age_t  m_age   [cache_pkg::ENTRIES];
	cache_pkg::data_t mem_model [2**cache_pkg::ADDR_W];

	logic             exp_hit, exp_fetch, exp_evict;
	cache_pkg::addr_t exp_addr, exp_evict_addr;
	cache_pkg::data_t exp_rdata, exp_evict_data;
	int evict_count, evict_base, fetch_count, fetch_base;
	int errors, timeouts, requests, tests_done, n;

	assign accept = ready && req_valid;

	assoc_cache uut (.*);

	backing_mem #(.FILL_KEY(FILL_KEY)) u_backing_mem (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			evict_count <= 0;
			fetch_count <= 0;
		end else begin
			if (evict_valid && evict_ack) evict_count <= evict_count + 1;
			if (fetch_req) fetch_count <= fetch_count + 1;
		end
	end

	task automatic finish_run();
		$display("tests %0d, requests %0d, errors %0d, timeouts %0d",
			tests_done, requests, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic report_test(input int num, input string what);
		tests_done++;
		$display("test %0d (%s) finished, errors so far %0d", num, what, errors);
	endtask

	function automatic bit cached(input cache_pkg::addr_t addr);
		bit found;
		found = 1'b0;
		for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
			if (m_valid[i] && m_tag[i] == addr) found = 1'b1;
		end
		return found;
	endfunction

	// ages step first, then the hit, the lowest free entry or the oldest entry is taken
	task automatic predict(input cache_pkg::op_e op, input cache_pkg::addr_t addr,
		input cache_pkg::data_t wdata);
		int slot;
		slot       = -1;
		exp_hit    = 1'b0;
		exp_fetch  = 1'b0;
		exp_evict  = 1'b0;
		exp_addr   = addr;
		evict_base = evict_count;
		fetch_base = fetch_count;
		for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
			if (m_valid[i] && m_age[i] != '0) m_age[i] = m_age[i] - cache_pkg::age_t'(1);
			if (slot < 0 && m_valid[i] && m_tag[i] == addr) slot = i;
		end
		exp_hit = (slot >= 0);
		for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
			if (slot < 0 && !m_valid[i]) slot = i;
		end
		if (slot < 0) begin
			slot = 0;
			for (int i = 1; i < cache_pkg::ENTRIES; i++) begin
				if (m_age[i] < m_age[slot]) slot = i; // ties stay with the lower index
			end
			exp_evict              = 1'b1;
			exp_evict_addr         = m_tag[slot];
			exp_evict_data         = m_data[slot];
			mem_model[m_tag[slot]] = m_data[slot];
		end
		if (!exp_hit && op == cache_pkg::OP_READ) begin
			exp_fetch    = 1'b1;
			m_data[slot] = mem_model[addr];
		end
		if (op == cache_pkg::OP_WRITE) m_data[slot] = wdata;
		m_tag[slot]   = addr;
		m_valid[slot] = 1'b1;
		m_age[slot]   = cache_pkg::AGE_MAX;
		exp_rdata     = m_data[slot];
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!ready) begin
			timeouts++;
			$display("timeout: ready stayed low for %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic wait_resp();
		int cycles;
		cycles = 0;
		while (!resp_valid && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!resp_valid) begin
			timeouts++;
			$display("timeout: no response for address %h within %0d cycles", exp_addr,
				WAIT_LIMIT);
		end
	endtask

	// after a timeout no further request is sent
	task automatic issue(input cache_pkg::op_e op, input cache_pkg::addr_t addr,
		input cache_pkg::data_t wdata);
		if (timeouts == 0) wait_ready();
		if (timeouts == 0) begin
			predict(op, addr, wdata);
			req_valid = 1'b1;
			req_op    = op;
			req_addr  = addr;
			req_wdata = wdata;
			@(posedge clk);
			#2;
			req_valid = 1'b0;
			requests++;
			wait_resp();
		end
	endtask

	initial begin
		void'($urandom(32'he6aa_ec38));
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = cache_pkg::OP_READ;
		req_addr = '0;
		req_wdata = '0;
		{exp_hit, exp_fetch, exp_evict} = '0;
		{exp_addr, exp_evict_addr, exp_rdata, exp_evict_data} = '0;
		{evict_base, fetch_base} = '0;
		{errors, timeouts, requests, tests_done, n} = '0;
		for (int i = 0; i < cache_pkg::ENTRIES; i++) begin
			m_valid[i] = 1'b0;
			m_tag[i]   = '0;
			m_data[i]  = '0;
			m_age[i]   = '0;
		end
		for (int a = 0; a < 2**cache_pkg::ADDR_W; a++) begin
			mem_model[a] = cache_pkg::data_t'(a) ^ FILL_KEY;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		issue(cache_pkg::OP_READ, 8'h10, '0);
		report_test(1, "read miss on empty cache");
		issue(cache_pkg::OP_READ, 8'h10, '0);
		report_test(2, "read hit latency");
		issue(cache_pkg::OP_WRITE, 8'h10, 16'h1234);
		issue(cache_pkg::OP_READ, 8'h10, '0);
		issue(cache_pkg::OP_WRITE, 8'h20, 16'hbeef);
		report_test(3, "write hit and write miss");

		for (int i = 1; i <= 6; i++) issue(cache_pkg::OP_READ, cache_pkg::addr_t'(8'h30 + i), '0);
		issue(cache_pkg::OP_READ, 8'h10, '0); // shape the ages before the first eviction
		issue(cache_pkg::OP_READ, 8'h33, '0);
		issue(cache_pkg::OP_READ, 8'h40, '0);
		for (int i = 0; i < 24; i++) begin
			issue((($urandom % 2) != 0) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ,
				cache_pkg::addr_t'(8'h30 + $urandom % 12), cache_pkg::data_t'($urandom));
		end
		report_test(4, "victim choice on a full cache");

		for (int i = 0; i < 10; i++) issue(cache_pkg::OP_READ, cache_pkg::addr_t'(8'h90 + i), '0);
		report_test(5, "eviction under back-pressure");

		issue(cache_pkg::OP_WRITE, 8'h55, 16'h5eed);
		while (cached(8'h55) && n < 16) begin
			issue(cache_pkg::OP_READ, cache_pkg::addr_t'(8'hc0 + n), '0);
			n++;
		end
		if (cached(8'h55)) begin
			errors++;
			$display("address 55 was never evicted after %0d misses", n);
		end
		issue(cache_pkg::OP_READ, 8'h55, '0);
		report_test(6, "refetch of a written-back word");

		repeat (2) @(posedge clk);
		finish_run();
	end

	a_reset_idle: assert property (@(posedge clk)
		$rose(rst_n) |-> ready && !resp_valid && !fetch_req && !evict_valid)
		else begin
			errors++;
			$display("ERR ready=%h resp_valid=%h fetch_req=%h evict_valid=%h after reset",
				ready, resp_valid, fetch_req, evict_valid);
		end

	a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> resp_rdata == exp_rdata)
		else begin
			errors++;
			$display("ERR resp_rdata=%h expected %h", resp_rdata, exp_rdata);
		end

	a_resp_ready: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |=> ready && !resp_valid)
		else begin
			errors++;
			$display("ERR ready=%h resp_valid=%h after response", ready, resp_valid);
		end

	// a hit answers exactly two cycles after acceptance
	a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		exp_hit && (resp_valid || $past(accept, 2)) |-> resp_valid && $past(accept, 2))
		else begin
			errors++;
			$display("ERR resp_valid=%h accept two cycles back=%h", resp_valid, $past(accept, 2));
		end

	a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> exp_fetch && fetch_addr == exp_addr && !evict_valid)
		else begin
			errors++;
			$display("ERR fetch_addr=%h expected %h exp_fetch=%h evict_valid=%h",
				fetch_addr, exp_addr, exp_fetch, evict_valid);
		end

	a_fetch_done: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> fetch_count == fetch_base + (exp_fetch ? 1 : 0))
		else begin
			errors++;
			$display("ERR fetch_req count=%h expected %h", fetch_count - fetch_base, exp_fetch);
		end

	a_evict_victim: assert property (@(posedge clk) disable iff (!rst_n)
		evict_valid |-> exp_evict && evict_addr == exp_evict_addr &&
			evict_data == exp_evict_data)
		else begin
			errors++;
			$display("ERR evict_addr=%h expected %h evict_data=%h expected %h",
				evict_addr, exp_evict_addr, evict_data, exp_evict_data);
		end

	// the victim leaves before the new word is requested
	a_evict_first: assert property (@(posedge clk) disable iff (!rst_n)
		(fetch_req || resp_valid) && exp_evict |-> evict_count == evict_base + 1)
		else begin
			errors++;
			$display("ERR evict_ack count=%h expected 1", evict_count - evict_base);
		end

	a_evict_stable: assert property (@(posedge clk) disable iff (!rst_n)
		evict_valid && !evict_ack |=> evict_valid && $stable(evict_addr) && $stable(evict_data))
		else begin
			errors++;
			$display("ERR evict_valid=%h evict_addr=%h evict_data=%h changed before ack",
				evict_valid, evict_addr, evict_data);
		end

	a_evict_busy: assert property (@(posedge clk) disable iff (!rst_n)
		evict_valid |-> !ready)
		else begin
			errors++;
			$display("ERR ready=%h during eviction", ready);
		end

endmodule

`default_nettype wire

// File: filelist.f
common/cache_pkg.sv
common/entry_bus_if.sv
cache_store/entry_array.sv
cache_store/age_timers.sv
hdl/victim_scan.sv
hdl/miss_control.sv
hdl/assoc_cache.sv
dv/backing_mem.sv
dv/tb_assoc_cache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_assoc_cache
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
